/* Bender.yml */
package:
  name: ext_periph_subsystem

sources:
  # design, in compile order
  - src/ext_periph_pkg.sv
  - src/periph_addr_decode.sv
  - src/gpio_cnt_periph.sv
  - src/iffifo_periph.sv
  - src/periph_resp_collect.sv
  - src/ext_periph_subsystem.sv

  # testbench
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_ext_periph.sv

/* sources.f */
src/ext_periph_pkg.sv
src/periph_addr_decode.sv
src/gpio_cnt_periph.sv
src/iffifo_periph.sv
src/periph_resp_collect.sv
src/ext_periph_subsystem.sv
tb/tb_clk_gen.sv
tb/tb_ext_periph.sv

/* src/ext_periph_pkg.sv */
/*
 * external peripheral subsystem shared definitions
 * bus widths, address map, register offsets and interrupt indices
 */
package ext_periph_pkg;

  // register bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // address map
  // upper half of the address is common to every peripheral
  localparam logic [15:0] PERIPH_BASE = 16'h2000;
  localparam int unsigned NUM_PERIPH = 2;
  localparam int unsigned PERIPH_IDX_W = 4;
  localparam int unsigned GPIO_CNT_IDX = 0;
  localparam int unsigned IFFIFO_IDX = 1;
  localparam int unsigned OFFSET_W = 10;

  // gpio counter registers, word offsets
  localparam logic [OFFSET_W-1:0] GPIO_CTRL_OFS = OFFSET_W'(0);
  localparam logic [OFFSET_W-1:0] GPIO_CNT_OFS = OFFSET_W'(1);
  // bit 0 sticky wrap flag, write 1 to clear
  localparam logic [OFFSET_W-1:0] GPIO_STATUS_OFS = OFFSET_W'(2);

  // fifo registers, word offsets
  localparam logic [OFFSET_W-1:0] FIFO_DATA_IN_OFS = OFFSET_W'(0);
  localparam logic [OFFSET_W-1:0] FIFO_DATA_OUT_OFS = OFFSET_W'(1);
  // bit 0 empty, bit 1 full, bits 15:8 fill count
  localparam logic [OFFSET_W-1:0] FIFO_STATUS_OFS = OFFSET_W'(2);
  localparam logic [OFFSET_W-1:0] FIFO_WMARK_OFS = OFFSET_W'(3);

  // interrupt vector layout
  localparam int unsigned NUM_INTR = 2;
  localparam int unsigned INTR_GPIO_CNT = 0;
  localparam int unsigned INTR_IFFIFO = 1;

  // bus address seen either as a raw word or as its decode fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [15:0]             base;
      logic [PERIPH_IDX_W-1:0] idx;
      logic [OFFSET_W-1:0]     offset;
      logic [1:0]              byte_ofs;
    } fields;
  } periph_addr_u;

endpackage

/* src/ext_periph_subsystem.sv */
/*
 * external peripheral subsystem
 * register bus slave with address decode, gpio counter and interfaced fifo
 */
`timescale 1ns/100ps

module ext_periph_subsystem #(
  parameter int unsigned GPIO_CNT_MAX = 2048,
  parameter int unsigned FIFO_DEPTH   = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                reg_valid_i,
  input  logic                                reg_write_i,
  input  logic [ext_periph_pkg::ADDR_W-1:0]   reg_addr_i,
  input  logic [ext_periph_pkg::DATA_W-1:0]   reg_wdata_i,
  output logic [ext_periph_pkg::DATA_W-1:0]   reg_rdata_o,
  output logic                                reg_error_o,
  output logic                                reg_ready_o,
  input  logic                                gpio_i,
  output logic                                gpio_o,
  output logic [ext_periph_pkg::NUM_INTR-1:0] intr_o,
  output logic                                dma_slot_tx_o,
  output logic                                dma_slot_rx_o
);

  logic [ext_periph_pkg::NUM_PERIPH-1:0] sel;
  logic [ext_periph_pkg::OFFSET_W-1:0]   offset;
  logic                                  dec_error;
  logic [ext_periph_pkg::DATA_W-1:0]     gpio_rdata;
  logic [ext_periph_pkg::DATA_W-1:0]     fifo_rdata;
  logic                                  gpio_intr;
  logic                                  fifo_intr;

  periph_addr_decode periph_addr_decode_i (
    .reg_addr_i (reg_addr_i),
    .sel_o      (sel),
    .offset_o   (offset),
    .dec_error_o(dec_error)
  );

  gpio_cnt_periph #(
    .GPIO_CNT_MAX(GPIO_CNT_MAX)
  ) gpio_cnt_periph_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_valid_i (reg_valid_i),
    .reg_sel_i   (sel[ext_periph_pkg::GPIO_CNT_IDX]),
    .reg_write_i (reg_write_i),
    .reg_offset_i(offset),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (gpio_rdata),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .intr_o      (gpio_intr)
  );

  // tx slot is fifo not full, rx slot is fifo not empty
  iffifo_periph #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) iffifo_periph_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_valid_i (reg_valid_i),
    .reg_sel_i   (sel[ext_periph_pkg::IFFIFO_IDX]),
    .reg_write_i (reg_write_i),
    .reg_offset_i(offset),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (fifo_rdata),
    .in_ready_o  (dma_slot_tx_o),
    .out_valid_o (dma_slot_rx_o),
    .intr_o      (fifo_intr)
  );

  periph_resp_collect periph_resp_collect_i (
    .reg_valid_i (reg_valid_i),
    .sel_i       (sel),
    .dec_error_i (dec_error),
    .gpio_rdata_i(gpio_rdata),
    .fifo_rdata_i(fifo_rdata),
    .gpio_intr_i (gpio_intr),
    .fifo_intr_i (fifo_intr),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .reg_ready_o (reg_ready_o),
    .intr_o      (intr_o)
  );

endmodule

/* src/gpio_cnt_periph.sv */
/*
 * gpio rising-edge counter peripheral
 * toggles gpio_o and sets a sticky interrupt each time the count wraps
 */
`timescale 1ns/100ps

module gpio_cnt_periph #(
  parameter int unsigned GPIO_CNT_MAX = 2048
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                reg_valid_i,
  input  logic                                reg_sel_i,
  input  logic                                reg_write_i,
  input  logic [ext_periph_pkg::OFFSET_W-1:0] reg_offset_i,
  input  logic [ext_periph_pkg::DATA_W-1:0]   reg_wdata_i,
  output logic [ext_periph_pkg::DATA_W-1:0]   reg_rdata_o,
  input  logic                                gpio_i,
  output logic                                gpio_o,
  output logic                                intr_o
);

  // count runs 0 .. GPIO_CNT_MAX-1
  localparam int unsigned CNT_W = $clog2(GPIO_CNT_MAX);

  logic             gpio_s_q;
  logic             gpio_d_q;
  logic             rise;
  logic             en_q;
  logic [CNT_W-1:0] cnt_q;
  logic             wrap_q;
  logic             gpio_out_q;
  logic             wr_access;
  logic             at_max;

  assign wr_access = reg_valid_i && reg_sel_i && reg_write_i;
  assign rise = gpio_s_q && !gpio_d_q;
  assign at_max = (cnt_q == CNT_W'(GPIO_CNT_MAX - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_s_q   <= 1'b0;
      gpio_d_q   <= 1'b0;
      en_q       <= 1'b0;
      cnt_q      <= '0;
      wrap_q     <= 1'b0;
      gpio_out_q <= 1'b0;
    end else begin
      // sample and delay for edge detection
      gpio_s_q <= gpio_i;
      gpio_d_q <= gpio_s_q;

      if (wr_access && (reg_offset_i == ext_periph_pkg::GPIO_CTRL_OFS)) begin
        en_q <= reg_wdata_i[0];
      end

      if (wr_access && (reg_offset_i == ext_periph_pkg::GPIO_STATUS_OFS) && reg_wdata_i[0]) begin
        wrap_q <= 1'b0;
      end

      if (en_q && rise) begin
        if (at_max) begin
          cnt_q      <= '0;
          gpio_out_q <= !gpio_out_q;
          // a wrap in the same cycle as a clear wins
          wrap_q     <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_offset_i)
      ext_periph_pkg::GPIO_CTRL_OFS:   reg_rdata_o[0] = en_q;
      ext_periph_pkg::GPIO_CNT_OFS:    reg_rdata_o[CNT_W-1:0] = cnt_q;
      ext_periph_pkg::GPIO_STATUS_OFS: reg_rdata_o[0] = wrap_q;
      default:                         reg_rdata_o = '0;
    endcase
  end

  assign gpio_o = gpio_out_q;
  assign intr_o = wrap_q;

endmodule

/* src/iffifo_periph.sv */
/*
 * register-accessed fifo peripheral
 * push and pop registers, watermark interrupt and dma slot levels
 */
`timescale 1ns/100ps

module iffifo_periph #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                reg_valid_i,
  input  logic                                reg_sel_i,
  input  logic                                reg_write_i,
  input  logic [ext_periph_pkg::OFFSET_W-1:0] reg_offset_i,
  input  logic [ext_periph_pkg::DATA_W-1:0]   reg_wdata_i,
  output logic [ext_periph_pkg::DATA_W-1:0]   reg_rdata_o,
  output logic                                in_ready_o,
  output logic                                out_valid_o,
  output logic                                intr_o
);

  // depth is a power of two, so pointers wrap on their own
  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  logic [ext_periph_pkg::DATA_W-1:0] mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]                  wr_ptr_q;
  logic [PTR_W-1:0]                  rd_ptr_q;
  logic [CNT_W-1:0]                  cnt_q;
  logic [7:0]                        cnt_ext;
  logic [7:0]                        wmark_q;
  logic                              access;
  logic                              empty;
  logic                              full;
  logic                              push;
  logic                              pop;

  assign access = reg_valid_i && reg_sel_i;
  assign empty = (cnt_q == '0);
  assign full = (cnt_q == CNT_W'(FIFO_DEPTH));
  assign cnt_ext = 8'(cnt_q);

  // push when full and pop when empty are dropped
  assign push = access && reg_write_i &&
                (reg_offset_i == ext_periph_pkg::FIFO_DATA_IN_OFS) && !full;
  assign pop = access && !reg_write_i &&
               (reg_offset_i == ext_periph_pkg::FIFO_DATA_OUT_OFS) && !empty;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      wmark_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        cnt_q    <= cnt_q + 1'b1;
      end else if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        cnt_q    <= cnt_q - 1'b1;
      end

      if (access && reg_write_i && (reg_offset_i == ext_periph_pkg::FIFO_WMARK_OFS)) begin
        wmark_q <= reg_wdata_i[7:0];
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= reg_wdata_i;
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_offset_i)
      ext_periph_pkg::FIFO_DATA_OUT_OFS: begin
        if (!empty) begin
          reg_rdata_o = mem_q[rd_ptr_q];
        end
      end
      ext_periph_pkg::FIFO_STATUS_OFS: begin
        reg_rdata_o[0]    = empty;
        reg_rdata_o[1]    = full;
        reg_rdata_o[15:8] = cnt_ext;
      end
      ext_periph_pkg::FIFO_WMARK_OFS: reg_rdata_o[7:0] = wmark_q;
      default:                        reg_rdata_o = '0;
    endcase
  end

  // a zero watermark disables the interrupt
  assign intr_o = (wmark_q != '0) && (cnt_ext >= wmark_q);

  // dma slot levels
  assign in_ready_o = !full;
  assign out_valid_o = !empty;

endmodule

/* src/periph_addr_decode.sv */
/*
 * peripheral address decoder
 * one-hot peripheral select, register word offset and decode error
 */
`timescale 1ns/100ps

module periph_addr_decode (
  input  logic [ext_periph_pkg::ADDR_W-1:0]     reg_addr_i,
  output logic [ext_periph_pkg::NUM_PERIPH-1:0] sel_o,
  output logic [ext_periph_pkg::OFFSET_W-1:0]   offset_o,
  output logic                                  dec_error_o
);

  ext_periph_pkg::periph_addr_u addr_u;
  logic base_hit;
  logic idx_in_range;

  // raw view in, field view out
  assign addr_u.raw = reg_addr_i;

  assign base_hit = (addr_u.fields.base == ext_periph_pkg::PERIPH_BASE);
  assign idx_in_range = (addr_u.fields.idx < ext_periph_pkg::NUM_PERIPH);

  assign dec_error_o = !base_hit || !idx_in_range;

  // byte offset is dropped, registers are word aligned
  assign offset_o = addr_u.fields.offset;

  // nothing selected on a decode error
  always_comb begin
    sel_o = '0;
    for (int i = 0; i < ext_periph_pkg::NUM_PERIPH; i++) begin
      if (!dec_error_o && (addr_u.fields.idx == i)) begin
        sel_o[i] = 1'b1;
      end
    end
  end

endmodule

/* src/periph_resp_collect.sv */
/*
 * response collector
 * read data and error back to the bus, interrupt vector assembly
 */
`timescale 1ns/100ps

module periph_resp_collect (
  input  logic                                  reg_valid_i,
  input  logic [ext_periph_pkg::NUM_PERIPH-1:0] sel_i,
  input  logic                                  dec_error_i,
  input  logic [ext_periph_pkg::DATA_W-1:0]     gpio_rdata_i,
  input  logic [ext_periph_pkg::DATA_W-1:0]     fifo_rdata_i,
  input  logic                                  gpio_intr_i,
  input  logic                                  fifo_intr_i,
  output logic [ext_periph_pkg::DATA_W-1:0]     reg_rdata_o,
  output logic                                  reg_error_o,
  output logic                                  reg_ready_o,
  output logic [ext_periph_pkg::NUM_INTR-1:0]   intr_o
);

  always_comb begin
    reg_rdata_o = '0;
    if (!dec_error_i) begin
      if (sel_i[ext_periph_pkg::GPIO_CNT_IDX]) begin
        reg_rdata_o = gpio_rdata_i;
      end
      if (sel_i[ext_periph_pkg::IFFIFO_IDX]) begin
        reg_rdata_o = fifo_rdata_i;
      end
    end
  end

  assign reg_error_o = reg_valid_i && dec_error_i;

  // no back-pressure
  assign reg_ready_o = reg_valid_i;

  always_comb begin
    intr_o = '0;
    intr_o[ext_periph_pkg::INTR_GPIO_CNT] = gpio_intr_i;
    intr_o[ext_periph_pkg::INTR_IFFIFO]   = fifo_intr_i;
  end

endmodule

/* tb/tb_clk_gen.sv */
/*
 * testbench clock and reset generator
 */
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter real         PERIOD_NS  = 4.0,
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = !clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* tb/tb_ext_periph.sv */
/*
 * testbench for the external peripheral subsystem
 * bus accesses and pin levels checked against a reference model
 */
`timescale 1ns/100ps

module tb_ext_periph;

  localparam int unsigned CNT_MAX     = 8;
  localparam int unsigned DEPTH       = 8;
  localparam int unsigned CYCLE_LIMIT = 2000;
  localparam int unsigned GPIO        = ext_periph_pkg::GPIO_CNT_IDX;
  localparam int unsigned FIFO        = ext_periph_pkg::IFFIFO_IDX;

  logic                                clk;
  logic                                rst_n;
  logic                                reg_valid;
  logic                                reg_write;
  logic [ext_periph_pkg::ADDR_W-1:0]   reg_addr;
  logic [ext_periph_pkg::DATA_W-1:0]   reg_wdata;
  logic [ext_periph_pkg::DATA_W-1:0]   reg_rdata;
  logic                                reg_error;
  logic                                reg_ready;
  logic                                gpio_in;
  logic                                gpio_out;
  logic [ext_periph_pkg::NUM_INTR-1:0] intr;
  logic                                dma_slot_tx;
  logic                                dma_slot_rx;

  // reference model state
  logic [31:0] m_fifo[$];
  logic [7:0]  m_wmark;
  int unsigned m_cnt;
  logic        m_en;
  logic        m_wrap;
  logic        m_gpio_out;

  // expected responses, one entry per bus access
  logic [31:0] exp_data_q[$];
  logic        exp_err_q[$];
  logic        exp_rd_q[$];

  int unsigned cycles;
  int unsigned num_checks;
  int unsigned num_errors;
  int unsigned num_tests;
  int unsigned num_failed;
  int unsigned test_err_start;
  integer      seed;

  tb_clk_gen #(
    .PERIOD_NS (4.0),
    .RST_CYCLES(4)
  ) tb_clk_gen_i (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  ext_periph_subsystem #(
    .GPIO_CNT_MAX(CNT_MAX),
    .FIFO_DEPTH  (DEPTH)
  ) dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .reg_error_o  (reg_error),
    .reg_ready_o  (reg_ready),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .intr_o       (intr),
    .dma_slot_tx_o(dma_slot_tx),
    .dma_slot_rx_o(dma_slot_rx)
  );

  function automatic logic [31:0] make_addr(int unsigned idx, int unsigned ofs);
    return {ext_periph_pkg::PERIPH_BASE, 4'(idx), 10'(ofs), 2'b00};
  endfunction

  // {error, read data} of an access, from the model state before it
  function automatic logic [32:0] expected_resp(logic [31:0] addr);
    logic [9:0]  ofs;
    logic [31:0] data;
    ofs  = addr[11:2];
    data = '0;
    if ((addr[31:16] != 16'h2000) || (addr[15:12] >= 4'd2)) begin
      return {1'b1, 32'h0};
    end
    if (addr[15:12] == 4'(GPIO)) begin
      case (ofs)
        ext_periph_pkg::GPIO_CTRL_OFS:   data[0] = m_en;
        ext_periph_pkg::GPIO_CNT_OFS:    data = m_cnt;
        ext_periph_pkg::GPIO_STATUS_OFS: data[0] = m_wrap;
        default:                         data = '0;
      endcase
    end else begin
      case (ofs)
        ext_periph_pkg::FIFO_DATA_OUT_OFS: begin
          if (m_fifo.size() != 0) begin
            data = m_fifo[0];
          end
        end
        ext_periph_pkg::FIFO_STATUS_OFS: begin
          data[0]    = (m_fifo.size() == 0);
          data[1]    = (m_fifo.size() == DEPTH);
          data[15:8] = 8'(m_fifo.size());
        end
        ext_periph_pkg::FIFO_WMARK_OFS: data[7:0] = m_wmark;
        default:                        data = '0;
      endcase
    end
    return {1'b0, data};
  endfunction

  task automatic update_model(logic wr, logic [31:0] addr, logic [31:0] wdata);
    logic [32:0] resp;
    logic [9:0]  ofs;
    resp = expected_resp(addr);
    ofs  = addr[11:2];
    if (resp[32]) begin
      return;
    end
    if (addr[15:12] == 4'(GPIO)) begin
      if (wr && (ofs == ext_periph_pkg::GPIO_CTRL_OFS)) begin
        m_en = wdata[0];
      end
      if (wr && (ofs == ext_periph_pkg::GPIO_STATUS_OFS) && wdata[0]) begin
        m_wrap = 1'b0;
      end
    end else begin
      if (wr && (ofs == ext_periph_pkg::FIFO_DATA_IN_OFS) && (m_fifo.size() < DEPTH)) begin
        m_fifo.push_back(wdata);
      end
      if (wr && (ofs == ext_periph_pkg::FIFO_WMARK_OFS)) begin
        m_wmark = wdata[7:0];
      end
      if (!wr && (ofs == ext_periph_pkg::FIFO_DATA_OUT_OFS) && (m_fifo.size() != 0)) begin
        void'(m_fifo.pop_front());
      end
    end
  endtask

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("ERROR at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic bus_access(logic wr, logic [31:0] addr, logic [31:0] wdata);
    logic [32:0] resp;
    @(negedge clk);
    resp      = expected_resp(addr);
    reg_valid = 1'b1;
    reg_write = wr;
    reg_addr  = addr;
    reg_wdata = wdata;
    exp_data_q.push_back(resp[31:0]);
    exp_err_q.push_back(resp[32]);
    exp_rd_q.push_back(!wr);
    update_model(wr, addr, wdata);
  endtask

  task automatic write_reg(int unsigned idx, int unsigned ofs, logic [31:0] data);
    bus_access(1'b1, make_addr(idx, ofs), data);
  endtask

  task automatic read_reg(int unsigned idx, int unsigned ofs);
    bus_access(1'b0, make_addr(idx, ofs), 32'h0);
  endtask

  task automatic idle_cycles(int unsigned n);
    repeat (n) begin
      @(negedge clk);
      reg_valid = 1'b0;
      reg_write = 1'b0;
    end
  endtask

  // one idle cycle, then compare the pin levels with the model
  task automatic check_pins();
    logic [1:0] exp_intr;
    idle_cycles(1);
    exp_intr[0] = m_wrap;
    exp_intr[1] = (m_wmark != 0) && (m_fifo.size() >= m_wmark);
    #1;
    check_value("gpio_o", gpio_out, m_gpio_out);
    check_value("intr_o", intr, exp_intr);
    check_value("dma_slot_tx_o", dma_slot_tx, m_fifo.size() < DEPTH);
    check_value("dma_slot_rx_o", dma_slot_rx, m_fifo.size() != 0);
    check_value("reg_ready_o while idle", reg_ready, 1'b0);
  endtask

  // each level held 3 cycles
  task automatic gpio_pulse();
    @(negedge clk);
    reg_valid = 1'b0;
    gpio_in   = 1'b1;
    idle_cycles(2);
    @(negedge clk);
    gpio_in = 1'b0;
    idle_cycles(2);
    if (m_en) begin
      if (m_cnt == CNT_MAX - 1) begin
        m_cnt      = 0;
        m_gpio_out = !m_gpio_out;
        m_wrap     = 1'b1;
      end else begin
        m_cnt++;
      end
    end
  endtask

  task automatic end_test(string name);
    num_tests++;
    if (num_errors == test_err_start) begin
      $display("test %s: ok", name);
    end else begin
      num_failed++;
      $display("test %s: %0d errors", name, num_errors - test_err_start);
    end
    test_err_start = num_errors;
  endtask

  // response checks, mid-cycle after the falling-edge drive
  initial begin : compare_resp
    logic [31:0] exp_data;
    logic        exp_err;
    logic        exp_rd;
    forever begin
      @(negedge clk);
      #1;
      if (reg_valid) begin
        if (exp_data_q.size() == 0) begin
          num_errors++;
          $display("bus access at %0t has no expected response queued", $time);
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_err  = exp_err_q.pop_front();
          exp_rd   = exp_rd_q.pop_front();
          check_value("reg_ready_o", reg_ready, 1'b1);
          check_value("reg_error_o", reg_error, exp_err);
          if (exp_rd) begin
            check_value("reg_rdata_o", reg_rdata, exp_data);
          end
        end
      end
    end
  end

  // limit well above the length of the test sequence
  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] data;
    seed           = 32'h4a17_97e3;
    reg_valid      = 1'b0;
    reg_write      = 1'b0;
    reg_addr       = '0;
    reg_wdata      = '0;
    gpio_in        = 1'b0;
    m_wmark        = '0;
    m_cnt          = 0;
    m_en           = 1'b0;
    m_wrap         = 1'b0;
    m_gpio_out     = 1'b0;
    num_checks     = 0;
    num_errors     = 0;
    num_tests      = 0;
    num_failed     = 0;
    test_err_start = 0;
    @(posedge rst_n);

    check_pins();
    read_reg(FIFO, ext_periph_pkg::FIFO_STATUS_OFS);
    read_reg(GPIO, ext_periph_pkg::GPIO_CNT_OFS);
    read_reg(FIFO, ext_periph_pkg::FIFO_WMARK_OFS);
    idle_cycles(1);
    end_test("reset state");

    // wrong base, then index out of range
    bus_access(1'b0, 32'h3000_1008, 32'h0);
    bus_access(1'b1, 32'h2100_1000, 32'hdead_beef);
    bus_access(1'b0, make_addr(2, 2), 32'h0);
    bus_access(1'b1, make_addr(15, 0), 32'h1);
    bus_access(1'b1, 32'h0000_0000, 32'h1);
    read_reg(FIFO, ext_periph_pkg::FIFO_STATUS_OFS);
    read_reg(GPIO, ext_periph_pkg::GPIO_CTRL_OFS);
    check_pins();
    end_test("decode errors");

    repeat (DEPTH + 2) begin
      data = $random(seed);
      write_reg(FIFO, ext_periph_pkg::FIFO_DATA_IN_OFS, data);
    end
    read_reg(FIFO, ext_periph_pkg::FIFO_STATUS_OFS);
    check_pins();
    repeat (DEPTH) read_reg(FIFO, ext_periph_pkg::FIFO_DATA_OUT_OFS);
    // pop on empty
    read_reg(FIFO, ext_periph_pkg::FIFO_DATA_OUT_OFS);
    read_reg(FIFO, ext_periph_pkg::FIFO_STATUS_OFS);
    check_pins();
    end_test("fifo order and full");

    write_reg(FIFO, ext_periph_pkg::FIFO_WMARK_OFS, 32'h3);
    repeat (2) write_reg(FIFO, ext_periph_pkg::FIFO_DATA_IN_OFS, $random(seed));
    check_pins();
    write_reg(FIFO, ext_periph_pkg::FIFO_DATA_IN_OFS, $random(seed));
    check_pins();
    read_reg(FIFO, ext_periph_pkg::FIFO_DATA_OUT_OFS);
    check_pins();
    end_test("fifo watermark");

    write_reg(GPIO, ext_periph_pkg::GPIO_CTRL_OFS, 32'h1);
    repeat (11) gpio_pulse();
    idle_cycles(4);
    read_reg(GPIO, ext_periph_pkg::GPIO_CNT_OFS);
    read_reg(GPIO, ext_periph_pkg::GPIO_STATUS_OFS);
    check_pins();
    write_reg(GPIO, ext_periph_pkg::GPIO_STATUS_OFS, 32'h1);
    check_pins();
    read_reg(GPIO, ext_periph_pkg::GPIO_STATUS_OFS);
    // counter off, edges ignored
    write_reg(GPIO, ext_periph_pkg::GPIO_CTRL_OFS, 32'h0);
    repeat (3) gpio_pulse();
    idle_cycles(4);
    read_reg(GPIO, ext_periph_pkg::GPIO_CNT_OFS);
    check_pins();
    end_test("gpio counter wrap");

    idle_cycles(2);
    if (exp_data_q.size() != 0) begin
      num_errors++;
      $display("%0d expected responses were never checked", exp_data_q.size());
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             num_tests, num_failed, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
